/* sources.f */
rtl/sram_io_pkg.sv
rtl/host_regs.sv
rtl/serial_xfer_fsm.sv
rtl/bit_counter.sv
rtl/sram_word_shifter.sv
rtl/sram_io_ctrl.sv
verification/tb_sram_io_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the SRAM I/O controller testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
    --top-module tb_sram_io_ctrl \
    -f sources.f \
    -o sim_tb_sram_io_ctrl

./obj_dir/sim_tb_sram_io_ctrl

/* verification/tb_sram_io_ctrl.sv */
/*
 * Directed testbench for the SRAM I/O controller
 * Covers reset values, control levels, status, one-shots,
 * serial write and read against a chip serial model, and
 * the chip-internal modes.
 */

`timescale 1ns/100ps

module tb_sram_io_ctrl;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int LOAD_TIMEOUT = 10;   // Cycles allowed for the load pulse
    localparam int REG_CPUCTRL   = 0;
    localparam int REG_SRAM_ADDR = 1;
    localparam int REG_SRAM_DATA = 2;
    localparam int REG_ADC       = 3;

    logic                     csi_clk;
    logic                     rsi_reset_n;
    logic [31:0]              avs_cpuctrl_writedata;
    logic                     avs_cpuctrl_write;
    logic [31:0]              avs_sram_addr_writedata;
    logic                     avs_sram_addr_write;
    logic [31:0]              avs_sram_data_writedata;
    logic                     avs_sram_data_write;
    logic [31:0]              avs_adc_writedata;
    logic                     avs_adc_write;
    logic [31:0]              avs_cpustat_readdata;
    logic [31:0]              avs_sram_addr_readdata;
    logic [31:0]              avs_sram_data_readdata;
    sram_io_pkg::chip_ctrl_t  chip_ctrl;
    logic [9:0]               chip_adc_value;
    logic                     chip_si;
    sram_io_pkg::chip_stat_t  chip_stat;
    logic                     chip_so;

    sram_io_ctrl uut (
        .csi_clk                 (csi_clk),
        .rsi_reset_n             (rsi_reset_n),
        .avs_cpuctrl_writedata   (avs_cpuctrl_writedata),
        .avs_cpuctrl_write       (avs_cpuctrl_write),
        .avs_sram_addr_writedata (avs_sram_addr_writedata),
        .avs_sram_addr_write     (avs_sram_addr_write),
        .avs_sram_data_writedata (avs_sram_data_writedata),
        .avs_sram_data_write     (avs_sram_data_write),
        .avs_adc_writedata       (avs_adc_writedata),
        .avs_adc_write           (avs_adc_write),
        .avs_cpustat_readdata    (avs_cpustat_readdata),
        .avs_sram_addr_readdata  (avs_sram_addr_readdata),
        .avs_sram_data_readdata  (avs_sram_data_readdata),
        .chip_ctrl               (chip_ctrl),
        .chip_adc_value          (chip_adc_value),
        .chip_si                 (chip_si),
        .chip_stat               (chip_stat),
        .chip_so                 (chip_so)
    );

    initial
    begin
        csi_clk = 1'b0;
        forever #(CLK_PERIOD / 2) csi_clk = ~csi_clk;
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic abort_run;
        $display("Finished with errors");
        $fatal(1, "Simulation stopped on failure");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            abort_run();
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle;
        @(posedge csi_clk);
        #1;
    endtask

    task automatic bus_write(input int target, input logic [31:0] value);
        case (target)
            REG_CPUCTRL:
            begin
                avs_cpuctrl_writedata = value;
                avs_cpuctrl_write     = 1'b1;
            end
            REG_SRAM_ADDR:
            begin
                avs_sram_addr_writedata = value;
                avs_sram_addr_write     = 1'b1;
            end
            REG_SRAM_DATA:
            begin
                avs_sram_data_writedata = value;
                avs_sram_data_write     = 1'b1;
            end
            default:
            begin
                avs_adc_writedata = value;
                avs_adc_write     = 1'b1;
            end
        endcase
        next_cycle();
        avs_cpuctrl_write   = 1'b0;
        avs_sram_addr_write = 1'b0;
        avs_sram_data_write = 1'b0;
        avs_adc_write       = 1'b0;
    endtask

    // Control word with the chip out of reset
    function automatic logic [31:0] make_ctrl(input logic [1:0] mode, input logic load,
                                              input logic cpu_bgn);
        logic [31:0] word;
        word = '0;
        word[sram_io_pkg::IDX_RST_N]     = 1'b1;
        word[sram_io_pkg::IDX_CTRL_MOD0] = mode[0];
        word[sram_io_pkg::IDX_CTRL_MOD1] = mode[1];
        word[sram_io_pkg::IDX_CTRL_LOAD] = load;
        word[sram_io_pkg::IDX_CPU_BGN]   = cpu_bgn;
        return word;
    endfunction

    task automatic wait_load;
        int waited;
        waited = 0;
        while (chip_ctrl.ctrl_load !== 1'b1)
        begin
            if (waited >= LOAD_TIMEOUT)
            begin
                $display("Timed out waiting for the load pulse at %0t ns", $time);
                abort_run();
            end
            else
            begin
                next_cycle();
                waited++;
            end
        end
    endtask

    // Chip model: bit k on chip_so from E(k) to E(k+1)
    task automatic drive_chip_word(input logic [17:0] word);
        for (int k = 0; k < 18; k++)
        begin
            chip_so = word[k];
            next_cycle();
        end
        chip_so = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------
    task automatic test_reset;
        check_equal(32'(chip_ctrl), 32'd0, "chip_ctrl after reset");
        check_equal(32'(chip_adc_value), 32'd0, "chip_adc_value after reset");
        check_equal(32'(chip_si), 32'd0, "chip_si after reset");
        check_equal(avs_sram_addr_readdata, 32'd0, "addr readback after reset");
        check_equal(avs_sram_data_readdata, 32'd0, "data readback after reset");
    endtask

    task automatic test_levels_status;
        logic [31:0] ctrl_word;
        logic [31:0] adc_word;
        logic [31:0] stat_word;
        logic [31:0] expected_stat;
        for (int i = 0; i < 8; i++)
        begin
            ctrl_word = $urandom;
            ctrl_word[sram_io_pkg::IDX_CTRL_LOAD] = 1'b0;  // No pulses here
            ctrl_word[sram_io_pkg::IDX_CPU_BGN]   = 1'b0;
            ctrl_word[sram_io_pkg::IDX_CTRL_MOD0] = i[0];  // Every mode gets a turn
            ctrl_word[sram_io_pkg::IDX_CTRL_MOD1] = i[1];
            adc_word  = $urandom;
            stat_word = $urandom;
            chip_stat = sram_io_pkg::chip_stat_t'(stat_word[3:0]);
            bus_write(REG_CPUCTRL, ctrl_word);
            bus_write(REG_ADC, adc_word);
            check_equal(32'(chip_ctrl.ctrl_bgn), 32'(ctrl_word[sram_io_pkg::IDX_CTRL_BGN]),
                        "ctrl_bgn");
            check_equal(32'(chip_ctrl.cpu_wait), 32'(ctrl_word[sram_io_pkg::IDX_CPU_WAIT]),
                        "cpu_wait");
            check_equal(32'(chip_ctrl.app_done), 32'(ctrl_word[sram_io_pkg::IDX_APP_DONE]),
                        "app_done");
            check_equal(32'(chip_ctrl.rst_n), 32'(ctrl_word[sram_io_pkg::IDX_RST_N]), "rst_n");
            check_equal(32'(chip_ctrl.ctrl_mod0), 32'(ctrl_word[sram_io_pkg::IDX_CTRL_MOD0]),
                        "ctrl_mod0");
            // MOD1 only shows when MOD0 is set
            check_equal(32'(chip_ctrl.ctrl_mod1),
                        ctrl_word[sram_io_pkg::IDX_CTRL_MOD0] ?
                        32'(ctrl_word[sram_io_pkg::IDX_CTRL_MOD1]) : 32'd0, "ctrl_mod1");
            check_equal(32'(chip_adc_value), 32'(adc_word[9:0]), "chip_adc_value");
            // ctrl_rdy sits on top of the struct but at bit 0 of the status word
            expected_stat = {28'd0, stat_word[0], stat_word[1], stat_word[2], stat_word[3]};
            check_equal(avs_cpustat_readdata, expected_stat, "status word");
        end
    endtask

    task automatic test_one_shots;
        int bgn_count;
        int load_count;
        bus_write(REG_CPUCTRL, make_ctrl(2'b01, 1'b1, 1'b1));
        check_equal(32'(chip_ctrl.cpu_bgn), 32'd1, "cpu_bgn pulse");
        check_equal(32'(chip_ctrl.ctrl_load), 32'd1, "ctrl_load pulse");
        next_cycle();
        check_equal(32'(chip_ctrl.cpu_bgn), 32'd0, "cpu_bgn after pulse");
        check_equal(32'(chip_ctrl.ctrl_load), 32'd0, "ctrl_load after pulse");
        next_cycle();

        // Two writes in a row
        bgn_count  = 0;
        load_count = 0;
        avs_cpuctrl_writedata = make_ctrl(2'b11, 1'b1, 1'b1);
        avs_cpuctrl_write     = 1'b1;
        for (int i = 0; i < 5; i++)
        begin
            next_cycle();
            if (i == 1)
                avs_cpuctrl_write = 1'b0;
            bgn_count  += int'(chip_ctrl.cpu_bgn);
            load_count += int'(chip_ctrl.ctrl_load);
        end
        check_equal(32'(bgn_count), 32'd1, "cpu_bgn pulses in burst");
        check_equal(32'(load_count), 32'd1, "ctrl_load pulses in burst");
    endtask

    task automatic test_serial_write;
        logic [31:0] addr_word;
        logic [31:0] data_word;
        logic [17:0] expected_word;
        addr_word = $urandom;
        data_word = $urandom;
        expected_word = {addr_word[9:0], data_word[7:0]};
        bus_write(REG_SRAM_ADDR, addr_word);
        bus_write(REG_SRAM_DATA, data_word);
        bus_write(REG_CPUCTRL, make_ctrl(2'b00, 1'b1, 1'b0));
        wait_load();
        for (int k = 0; k < 18; k++)
        begin
            next_cycle();
            check_equal(32'(chip_si), 32'(expected_word[k]), $sformatf("chip_si bit %0d", k));
        end
        repeat (3) next_cycle();
    endtask

    task automatic test_serial_read;
        logic [31:0] rand_word;
        logic [17:0] chip_word;
        rand_word = $urandom;
        chip_word = rand_word[17:0];
        bus_write(REG_CPUCTRL, make_ctrl(2'b10, 1'b1, 1'b0));
        wait_load();
        drive_chip_word(chip_word);
        check_equal(avs_sram_addr_readdata, 32'(chip_word[17:8]), "addr readback");
        check_equal(avs_sram_data_readdata, 32'(chip_word[7:0]), "data readback");
        repeat (3) next_cycle();
    endtask

    task automatic test_internal_modes;
        logic [31:0] addr_before;
        logic [31:0] data_before;
        logic [31:0] rand_word;
        logic [1:0]  modes [2];
        modes[0] = 2'b01;
        modes[1] = 2'b11;
        for (int m = 0; m < 2; m++)
        begin
            addr_before = avs_sram_addr_readdata;
            data_before = avs_sram_data_readdata;
            bus_write(REG_CPUCTRL, make_ctrl(modes[m], 1'b1, 1'b0));
            for (int i = 0; i < 20; i++)
            begin
                rand_word = $urandom;
                chip_so   = rand_word[0];   // Noise must not reach the shifter
                next_cycle();
                check_equal(avs_sram_addr_readdata, addr_before, "addr readback, internal mode");
                check_equal(avs_sram_data_readdata, data_before, "data readback, internal mode");
            end
        end
        chip_so = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial
    begin
        rsi_reset_n             = 1'b0;
        avs_cpuctrl_writedata   = '0;
        avs_cpuctrl_write       = 1'b0;
        avs_sram_addr_writedata = '0;
        avs_sram_addr_write     = 1'b0;
        avs_sram_data_writedata = '0;
        avs_sram_data_write     = 1'b0;
        avs_adc_writedata       = '0;
        avs_adc_write           = 1'b0;
        chip_stat               = '0;
        chip_so                 = 1'b0;
        void'($urandom(32'h5e34));

        repeat (RESET_CYCLES) @(posedge csi_clk);
        #1;
        rsi_reset_n = 1'b1;
        next_cycle();

        test_reset();
        test_levels_status();
        test_one_shots();
        test_serial_write();
        test_serial_read();
        test_internal_modes();

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* rtl/sram_io_ctrl.sv */
/*
 * SRAM I/O controller top level
 * Host-side control of a test chip's instruction SRAM port.
 * Joins the register file, the transfer FSM, the bit counter
 * and the serial word shifter.
 */

`timescale 1ns/100ps

module sram_io_ctrl (
    input  logic                                csi_clk,
    input  logic                                rsi_reset_n,

    // Host bus
    input  logic [sram_io_pkg::AVS_WIDTH-1:0]   avs_cpuctrl_writedata,
    input  logic                                avs_cpuctrl_write,
    input  logic [sram_io_pkg::AVS_WIDTH-1:0]   avs_sram_addr_writedata,
    input  logic                                avs_sram_addr_write,
    input  logic [sram_io_pkg::AVS_WIDTH-1:0]   avs_sram_data_writedata,
    input  logic                                avs_sram_data_write,
    input  logic [sram_io_pkg::AVS_WIDTH-1:0]   avs_adc_writedata,
    input  logic                                avs_adc_write,
    output logic [sram_io_pkg::AVS_WIDTH-1:0]   avs_cpustat_readdata,
    output logic [sram_io_pkg::AVS_WIDTH-1:0]   avs_sram_addr_readdata,
    output logic [sram_io_pkg::AVS_WIDTH-1:0]   avs_sram_data_readdata,

    // Chip side
    output sram_io_pkg::chip_ctrl_t             chip_ctrl,
    output logic [sram_io_pkg::ADC_WIDTH-1:0]   chip_adc_value,
    output logic                                chip_si,
    input  sram_io_pkg::chip_stat_t             chip_stat,
    input  logic                                chip_so
);

    sram_io_pkg::sram_word_t  tx_word;
    sram_io_pkg::sram_word_t  rx_word;
    sram_io_pkg::xfer_mode_e  xfer_mode;
    sram_io_pkg::shift_op_e   shift_op;
    logic                     load_pulse;
    logic                     cnt_load;
    logic                     cnt_dec;
    logic                     cnt_zero;

    // ------------------------------------------------------------------
    // Host registers
    // ------------------------------------------------------------------
    host_regs u_host_regs (
        .csi_clk             (csi_clk),
        .rsi_reset_n         (rsi_reset_n),
        .cpuctrl_writedata   (avs_cpuctrl_writedata),
        .cpuctrl_write       (avs_cpuctrl_write),
        .sram_addr_writedata (avs_sram_addr_writedata),
        .sram_addr_write     (avs_sram_addr_write),
        .sram_data_writedata (avs_sram_data_writedata),
        .sram_data_write     (avs_sram_data_write),
        .adc_writedata       (avs_adc_writedata),
        .adc_write           (avs_adc_write),
        .chip_stat           (chip_stat),
        .chip_ctrl           (chip_ctrl),
        .adc_value           (chip_adc_value),
        .cpustat_readdata    (avs_cpustat_readdata),
        .tx_word             (tx_word),
        .load_pulse          (load_pulse),
        .xfer_mode           (xfer_mode)
    );

    // ------------------------------------------------------------------
    // Serial transfer path
    // ------------------------------------------------------------------
    serial_xfer_fsm u_serial_xfer_fsm (
        .csi_clk     (csi_clk),
        .rsi_reset_n (rsi_reset_n),
        .load_pulse  (load_pulse),
        .xfer_mode   (xfer_mode),
        .cnt_zero    (cnt_zero),
        .shift_op    (shift_op),
        .cnt_load    (cnt_load),
        .cnt_dec     (cnt_dec)
    );

    bit_counter u_bit_counter (
        .csi_clk     (csi_clk),
        .rsi_reset_n (rsi_reset_n),
        .cnt_load    (cnt_load),
        .cnt_dec     (cnt_dec),
        .cnt_zero    (cnt_zero)
    );

    sram_word_shifter u_sram_word_shifter (
        .csi_clk     (csi_clk),
        .rsi_reset_n (rsi_reset_n),
        .shift_op    (shift_op),
        .tx_word     (tx_word),
        .ctrl_so     (chip_so),
        .ctrl_si     (chip_si),
        .rx_word     (rx_word)
    );

    // Readback of the last serial word, zero extended
    assign avs_sram_addr_readdata = {{(sram_io_pkg::AVS_WIDTH - sram_io_pkg::ADDR_WIDTH){1'b0}},
                                     rx_word.addr};
    assign avs_sram_data_readdata = {{(sram_io_pkg::AVS_WIDTH - sram_io_pkg::DATA_WIDTH){1'b0}},
                                     rx_word.data};

endmodule

/* rtl/sram_word_shifter.sv */
/*
 * SRAM word shifter
 * 18-bit register with parallel load from the host registers
 * and right shift, LSB out to the chip and chip data in at
 * the MSB.
 */

`timescale 1ns/100ps

module sram_word_shifter (
    input  logic                    csi_clk,
    input  logic                    rsi_reset_n,
    input  sram_io_pkg::shift_op_e  shift_op,
    input  sram_io_pkg::sram_word_t tx_word,
    input  logic                    ctrl_so,
    output logic                    ctrl_si,
    output sram_io_pkg::sram_word_t rx_word
);

    sram_io_pkg::sram_word_t word_q;

    // ------------------------------------------------------------------
    // Shift register
    // ------------------------------------------------------------------
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            word_q <= '0;
        end
        else
        begin
            case (shift_op)
                sram_io_pkg::OP_LOAD:
                begin
                    word_q <= tx_word;
                end
                sram_io_pkg::OP_SHIFT:
                begin
                    // Chip bit enters at the top, ends at bit 0 after a full word
                    word_q <= {ctrl_so, word_q[sram_io_pkg::WORD_WIDTH-1:1]};
                end
                default:
                begin
                    word_q <= word_q;     // Hold
                end
            endcase
        end
    end

    assign ctrl_si = word_q[0];           // Data LSB leaves first
    assign rx_word = word_q;

endmodule

/* rtl/bit_counter.sv */
/*
 * Bit counter
 * Down counter that times the bits of one serial word and
 * flags when the count is exhausted.
 */

`timescale 1ns/100ps

module bit_counter (
    input  logic csi_clk,
    input  logic rsi_reset_n,
    input  logic cnt_load,
    input  logic cnt_dec,
    output logic cnt_zero
);

    logic [sram_io_pkg::CNT_WIDTH-1:0] count_q;

    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
            count_q <= '0;
        else if (cnt_load)
            count_q <= sram_io_pkg::CNT_LOAD;   // Word length minus one
        else if (cnt_dec)
            count_q <= count_q - 1'b1;
    end

    assign cnt_zero = (count_q == '0);

    // The FSM must stop stepping once the word is done
    a_no_underflow: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
        cnt_dec |-> !cnt_zero);

endmodule

/* rtl/serial_xfer_fsm.sv */
/*
 * Serial transfer FSM
 * Starts a shift-out or shift-in on a load pulse in a serial
 * mode, then steps the shifter and the bit counter until the
 * count runs out.
 */

`timescale 1ns/100ps

module serial_xfer_fsm (
    input  logic                     csi_clk,
    input  logic                     rsi_reset_n,
    input  logic                     load_pulse,
    input  sram_io_pkg::xfer_mode_e  xfer_mode,
    input  logic                     cnt_zero,
    output sram_io_pkg::shift_op_e   shift_op,
    output logic                     cnt_load,
    output logic                     cnt_dec
);

    sram_io_pkg::xfer_state_e state_q;
    sram_io_pkg::xfer_state_e state_d;

    // ------------------------------------------------------------------
    // State register
    // ------------------------------------------------------------------
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
            state_q <= sram_io_pkg::ST_IDLE;
        else
            state_q <= state_d;
    end

    // ------------------------------------------------------------------
    // Next state and controls
    // ------------------------------------------------------------------
    always_comb
    begin
        state_d  = state_q;
        shift_op = sram_io_pkg::OP_HOLD;
        cnt_load = 1'b0;
        cnt_dec  = 1'b0;

        case (state_q)
            sram_io_pkg::ST_IDLE:
            begin
                // Chip-internal modes leave the shifter alone
                if (load_pulse && xfer_mode == sram_io_pkg::MODE_TO_CHIP)
                begin
                    shift_op = sram_io_pkg::OP_LOAD;    // Bit 0 goes out next cycle
                    cnt_load = 1'b1;
                    state_d  = sram_io_pkg::ST_SHIFT_OUT;
                end
                else if (load_pulse && xfer_mode == sram_io_pkg::MODE_FROM_CHIP)
                begin
                    shift_op = sram_io_pkg::OP_SHIFT;   // Bit 0 is already on ctrl_so
                    cnt_load = 1'b1;
                    state_d  = sram_io_pkg::ST_SHIFT_IN;
                end
            end

            sram_io_pkg::ST_SHIFT_OUT,
            sram_io_pkg::ST_SHIFT_IN:
            begin
                // Load pulses are ignored until the word is done
                if (!cnt_zero)
                begin
                    shift_op = sram_io_pkg::OP_SHIFT;
                    cnt_dec  = 1'b1;
                end
                else
                begin
                    state_d = sram_io_pkg::ST_IDLE;
                end
            end

            default:
            begin
                state_d = sram_io_pkg::ST_IDLE;
            end
        endcase
    end

    // A new word never restarts the counter mid-transfer
    a_load_only_idle: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
        cnt_load |-> state_q == sram_io_pkg::ST_IDLE);

endmodule

/* rtl/host_regs.sv */
/*
 * Host register file
 * Decodes the control word into chip levels and one-shot pulses,
 * keeps the SRAM address, SRAM data and ADC registers, and packs
 * the chip status inputs into the status word.
 */

`timescale 1ns/100ps

module host_regs (
    input  logic                                   csi_clk,
    input  logic                                   rsi_reset_n,
    input  logic [sram_io_pkg::AVS_WIDTH-1:0]      cpuctrl_writedata,
    input  logic                                   cpuctrl_write,
    input  logic [sram_io_pkg::AVS_WIDTH-1:0]      sram_addr_writedata,
    input  logic                                   sram_addr_write,
    input  logic [sram_io_pkg::AVS_WIDTH-1:0]      sram_data_writedata,
    input  logic                                   sram_data_write,
    input  logic [sram_io_pkg::AVS_WIDTH-1:0]      adc_writedata,
    input  logic                                   adc_write,
    input  sram_io_pkg::chip_stat_t                chip_stat,
    output sram_io_pkg::chip_ctrl_t                chip_ctrl,
    output logic [sram_io_pkg::ADC_WIDTH-1:0]      adc_value,
    output logic [sram_io_pkg::AVS_WIDTH-1:0]      cpustat_readdata,
    output sram_io_pkg::sram_word_t                tx_word,
    output logic                                   load_pulse,
    output sram_io_pkg::xfer_mode_e                xfer_mode
);

    logic                                cpuctrl_write_q;   // Write seen last cycle
    logic                                first_write;
    logic                                cpu_bgn_q;
    logic                                ctrl_load_q;
    logic                                ctrl_bgn_q;
    logic                                app_done_q;
    logic                                rst_n_q;
    logic                                cpu_wait_q;
    logic [1:0]                          mode_q;            // {MOD1, MOD0}
    logic [sram_io_pkg::ADDR_WIDTH-1:0]  addr_q;
    logic [sram_io_pkg::DATA_WIDTH-1:0]  data_q;
    logic [sram_io_pkg::ADC_WIDTH-1:0]   adc_q;

    // Only the first cycle of a write burst may fire a pulse
    assign first_write = cpuctrl_write && !cpuctrl_write_q;

    // ------------------------------------------------------------------
    // Control word decode and one-shots
    // ------------------------------------------------------------------
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            cpuctrl_write_q <= 1'b0;
            cpu_bgn_q       <= 1'b0;
            ctrl_load_q     <= 1'b0;
            ctrl_bgn_q      <= 1'b0;
            app_done_q      <= 1'b0;
            rst_n_q         <= 1'b0;  // Chip held in reset until released
            cpu_wait_q      <= 1'b0;
            mode_q          <= 2'b00;
            adc_q           <= '0;
        end
        else
        begin
            cpuctrl_write_q <= cpuctrl_write;
            cpu_bgn_q   <= first_write && cpuctrl_writedata[sram_io_pkg::IDX_CPU_BGN];
            ctrl_load_q <= first_write && cpuctrl_writedata[sram_io_pkg::IDX_CTRL_LOAD];

            if (cpuctrl_write)
            begin
                ctrl_bgn_q <= cpuctrl_writedata[sram_io_pkg::IDX_CTRL_BGN];
                app_done_q <= cpuctrl_writedata[sram_io_pkg::IDX_APP_DONE];
                rst_n_q    <= cpuctrl_writedata[sram_io_pkg::IDX_RST_N];
                cpu_wait_q <= cpuctrl_writedata[sram_io_pkg::IDX_CPU_WAIT];
                mode_q     <= {cpuctrl_writedata[sram_io_pkg::IDX_CTRL_MOD1],
                               cpuctrl_writedata[sram_io_pkg::IDX_CTRL_MOD0]};
            end

            if (adc_write)
                adc_q <= adc_writedata[sram_io_pkg::ADC_WIDTH-1:0];
        end
    end

    // SRAM word payload
    always_ff @(posedge csi_clk)
    begin
        if (sram_addr_write)
            addr_q <= sram_addr_writedata[sram_io_pkg::ADDR_WIDTH-1:0];
        if (sram_data_write)
            data_q <= sram_data_writedata[sram_io_pkg::DATA_WIDTH-1:0];
    end

    // ------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------
    always_comb
    begin
        chip_ctrl.cpu_bgn   = cpu_bgn_q;
        chip_ctrl.ctrl_bgn  = ctrl_bgn_q;
        chip_ctrl.ctrl_mod0 = mode_q[0];
        chip_ctrl.ctrl_mod1 = mode_q[0] ? mode_q[1] : 1'b0;  // Serial modes show 00
        chip_ctrl.ctrl_load = ctrl_load_q;
        chip_ctrl.cpu_wait  = cpu_wait_q;
        chip_ctrl.app_done  = app_done_q;
        chip_ctrl.rst_n     = rst_n_q;
    end

    always_comb
    begin
        cpustat_readdata = '0;
        cpustat_readdata[sram_io_pkg::IDX_CTRL_RDY]  = chip_stat.ctrl_rdy;
        cpustat_readdata[sram_io_pkg::IDX_NXT_END]   = chip_stat.nxt_end;
        cpustat_readdata[sram_io_pkg::IDX_NXT_CONT]  = chip_stat.nxt_cont;
        cpustat_readdata[sram_io_pkg::IDX_APP_START] = chip_stat.app_start;
    end

    assign adc_value    = adc_q;
    assign tx_word.addr = addr_q;
    assign tx_word.data = data_q;
    assign load_pulse   = ctrl_load_q;
    assign xfer_mode    = sram_io_pkg::xfer_mode_e'(mode_q);

    // Pulses last a single cycle even under a write burst
    a_cpu_bgn_one_shot: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
        cpu_bgn_q |=> !cpu_bgn_q);
    a_load_one_shot: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
        ctrl_load_q |=> !ctrl_load_q);

endmodule

/* rtl/sram_io_pkg.sv */
/*
 * SRAM I/O controller shared definitions
 * Bus and SRAM widths, control and status bit positions,
 * transfer mode, shifter opcode and FSM state encodings,
 * and the structs carried between the host side and the chip.
 */

package sram_io_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int AVS_WIDTH  = 32;                      // Host bus word
    localparam int ADDR_WIDTH = 10;
    localparam int DATA_WIDTH = 8;
    localparam int WORD_WIDTH = ADDR_WIDTH + DATA_WIDTH; // Serial word, 18 bits
    localparam int ADC_WIDTH  = 10;
    localparam int CNT_WIDTH  = 5;

    // Count preset for one serial word
    localparam logic [CNT_WIDTH-1:0] CNT_LOAD = CNT_WIDTH'(WORD_WIDTH - 1);

    // ------------------------------------------------------------------
    // Control word bits
    // ------------------------------------------------------------------
    localparam int IDX_CTRL_BGN  = 0;
    localparam int IDX_CTRL_LOAD = 1;   // One-shot
    localparam int IDX_CTRL_MOD0 = 2;
    localparam int IDX_CTRL_MOD1 = 3;
    localparam int IDX_APP_DONE  = 4;
    localparam int IDX_CPU_BGN   = 5;   // One-shot
    localparam int IDX_RST_N     = 6;
    localparam int IDX_CPU_WAIT  = 7;

    // Status word bits
    localparam int IDX_CTRL_RDY  = 0;
    localparam int IDX_NXT_END   = 1;
    localparam int IDX_NXT_CONT  = 2;
    localparam int IDX_APP_START = 3;

    // ------------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {
        MODE_TO_CHIP      = 2'b00,  // Serial write to chip
        MODE_SRAM_TO_CTRL = 2'b01,  // Chip internal
        MODE_FROM_CHIP    = 2'b10,  // Serial read from chip
        MODE_CTRL_TO_SRAM = 2'b11   // Chip internal
    } xfer_mode_e;

    typedef enum logic [1:0] {
        OP_HOLD  = 2'b00,
        OP_LOAD  = 2'b01,
        OP_SHIFT = 2'b10
    } shift_op_e;

    typedef enum logic [1:0] {
        ST_IDLE      = 2'b00,
        ST_SHIFT_OUT = 2'b01,
        ST_SHIFT_IN  = 2'b10
    } xfer_state_e;

    // Address sits above data, data leaves the chip port first
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } sram_word_t;

    typedef struct packed {
        logic cpu_bgn;
        logic ctrl_bgn;
        logic ctrl_mod0;
        logic ctrl_mod1;
        logic ctrl_load;
        logic cpu_wait;
        logic app_done;
        logic rst_n;
    } chip_ctrl_t;

    typedef struct packed {
        logic ctrl_rdy;
        logic nxt_end;
        logic nxt_cont;
        logic app_start;
    } chip_stat_t;

endpackage
